// File: list.f
+incdir+logic
+incdir+verification
logic/cpu_pkg.sv
logic/regFile.sv
logic/immLoader.sv
logic/addrUnit.sv
logic/fetchSequencer.sv
logic/cpuTop.sv
verification/cpuTb.sv

// File: logic/addrUnit.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module addrUnit import cpu_pkg::*; (
  input  logic               clk25,
  input  logic               arstN,
  input  addrCmd             cmd,
  input  logic [`OFS_W-1:0]  eaBase,
  input  logic [`REG_W-1:0]  dispValue,
  input  logic               step,
  output logic [`ADDR_W-1:0] address,
  output logic [`OFS_W-1:0]  curEa,
  output logic [`OFS_W-1:0]  curSeg
);

  logic [`OFS_W-1:0] ip;
  logic [`OFS_W-1:0] ea;
  logic [`OFS_W-1:0] savedEa;       // EA before operand bytes
  logic [`OFS_W-1:0] dispExt;
  logic [`OFS_W-1:0] eaDisp;
  logic              memMode;       // Set while operand bytes come from memory
  segSel             segQ;

  // ------------------------------------------------------------
  // Displacement
  // ------------------------------------------------------------
  assign dispExt = cmd.dispWide ? dispValue[15:0]
                                : {{8{dispValue[7]}}, dispValue[7:0]};  // Sign extend disp8
  assign eaDisp  = ea + dispExt;    // Zero base gives the direct address

  // Control
  always_ff @(posedge clk25 or negedge arstN) begin
    if (!arstN) begin
      ip      <= '0;
      memMode <= 1'b0;
      segQ    <= SEG_DS;
    end else begin
      memMode <= cmd.memMode;
      if (cmd.setSeg) begin
        segQ <= cmd.seg;
      end
      if (cmd.ipStep || (step && !memMode)) begin
        ip <= ip + 16'd1;           // Opcode, ModRM or disp byte
      end
    end
  end

  // Effective address
  always_ff @(posedge clk25) begin
    if (cmd.loadEaBase) begin
      ea      <= eaBase;
      savedEa <= eaBase;
    end else if (cmd.addDisp) begin
      ea      <= eaDisp;
      savedEa <= eaDisp;
    end else if (cmd.restoreEa) begin
      ea <= savedEa;
    end else if (step && memMode) begin
      ea <= ea + 16'd1;             // Next operand byte
    end
  end

  // ------------------------------------------------------------
  // Segment value and physical address
  // ------------------------------------------------------------
  always_comb begin
    case (segQ)
      SEG_ES:  curSeg = `RST_ES;
      SEG_CS:  curSeg = `RST_CS;
      SEG_SS:  curSeg = `RST_SS;
      default: curSeg = `RST_DS;
    endcase
  end

  assign address = {(memMode ? curSeg : `RST_CS), 4'b0000}
                 + {4'b0000, (memMode ? ea : ip)};
  assign curEa   = ea;

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpuTop import cpu_pkg::*; (
  input  logic               clk25,
  input  logic               arstN,
  input  logic [7:0]         din,        // Combinational memory data
  output logic [`ADDR_W-1:0] address,
  output logic               instrValid,
  output instrInfo           info
);

  addrCmd            cmd;
  immReq             immRq;
  logic              immBusy;
  logic              immStep;
  logic [`REG_W-1:0] immValue;
  logic [`REG_W-1:0] regValue;
  logic [`OFS_W-1:0] eaBase;
  logic [`OFS_W-1:0] curEa;
  logic [`OFS_W-1:0] curSeg;
  logic [2:0]        regSel;
  logic [1:0]        sizeSel;

  // ------------------------------------------------------------
  // Decode control
  // ------------------------------------------------------------
  fetchSequencer seq0 (
    .clk25      (clk25),
    .arstN      (arstN),
    .din        (din),
    .regValue   (regValue),
    .immBusy    (immBusy),
    .immValue   (immValue),
    .curEa      (curEa),
    .curSeg     (curSeg),
    .cmd        (cmd),
    .imm        (immRq),
    .regSel     (regSel),
    .sizeSel    (sizeSel),
    .instrValid (instrValid),
    .info       (info)
  );

  // Disp and memory operand bytes
  immLoader imm0 (
    .clk25 (clk25),
    .arstN (arstN),
    .din   (din),
    .req   (immRq),
    .busy  (immBusy),
    .step  (immStep),
    .value (immValue)
  );

  addrUnit addr0 (
    .clk25     (clk25),
    .arstN     (arstN),
    .cmd       (cmd),
    .eaBase    (eaBase),
    .dispValue (immValue),
    .step      (immStep),
    .address   (address),
    .curEa     (curEa),
    .curSeg    (curSeg)
  );

  regFile regs0 (
    .clk25    (clk25),
    .arstN    (arstN),
    .din      (din),
    .regSel   (regSel),
    .sizeSel  (sizeSel),
    .regValue (regValue),
    .eaBase   (eaBase)
  );

endmodule

// File: logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define ADDR_W 20                   // Physical address, seg*16 + offset
`define OFS_W  16                   // Offsets and segments
`define REG_W  32                   // General registers

// ------------------------------------------------------------
// Register values after reset
// ------------------------------------------------------------
`define RST_EAX 32'h7711_5544
`define RST_ECX 32'h0000_0000
`define RST_EDX 32'h0000_0000
`define RST_EBX 32'h0000_1122
`define RST_ESP 32'h0000_7799
`define RST_EBP 32'h0000_0400       // Nonzero so BP forms point at real data
`define RST_ESI 32'h0000_2233
`define RST_EDI 32'h0000_0000

// Code at 00000, data regions above 10000
`define RST_CS 16'h0000
`define RST_DS 16'h1000
`define RST_SS 16'h2000
`define RST_ES 16'h3000

`endif

// File: logic/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  // Top level sequencer states
  typedef enum logic [1:0] {
    INIT,                           // Clear per-instruction state
    FETCH,                          // Prefixes and opcode
    MODRM,                          // ModRM, disp and operands
    EXEC                            // Report
  } seqState;

  // Steps inside MODRM
  typedef enum logic [1:0] {
    MR_DECODE,                      // ModRM byte on din
    MR_REGREAD,                     // First operand, start memory load
    MR_CAPTURE                      // Second operand
  } modrmPhase;

  // Class of a fetched byte
  typedef enum logic [1:0] {
    PREFIX,
    PLAIN,
    WITH_MODRM
  } opClass;

  // Segment choice, x86 sreg order
  typedef enum logic [1:0] {
    SEG_ES,
    SEG_CS,
    SEG_SS,
    SEG_DS
  } segSel;

  // Per-cycle command to the address unit
  typedef struct packed {
    logic  ipStep;                  // Consume one code byte
    logic  memMode;                 // Next cycle reads segment:EA
    logic  loadEaBase;              // EA from the ModRM base sum
    logic  addDisp;                 // Add the loaded displacement
    logic  dispWide;                // Disp16 instead of disp8
    logic  restoreEa;               // Undo operand load increments
    logic  setSeg;
    segSel seg;
  } addrCmd;

  typedef struct packed {
    logic       start;
    logic [1:0] sizeM1;             // Bytes minus one
  } immReq;

  // Decoded instruction report
  typedef struct packed {
    logic [7:0]        opcode;
    logic [`OFS_W-1:0] segment;
    logic [`OFS_W-1:0] ea;
    logic [`REG_W-1:0] op1;
    logic [`REG_W-1:0] op2;
    logic              osize;
    logic              hasModrm;
  } instrInfo;

endpackage

// File: logic/fetchSequencer.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetchSequencer import cpu_pkg::*; (
  input  logic              clk25,
  input  logic              arstN,
  input  logic [7:0]        din,
  input  logic [`REG_W-1:0] regValue,
  input  logic              immBusy,
  input  logic [`REG_W-1:0] immValue,
  input  logic [`OFS_W-1:0] curEa,
  input  logic [`OFS_W-1:0] curSeg,
  output addrCmd            cmd,
  output immReq             imm,
  output logic [2:0]        regSel,
  output logic [1:0]        sizeSel,
  output logic              instrValid,
  output instrInfo          info
);

  seqState           state;
  modrmPhase         phase;
  logic [7:0]        opcode;
  logic [7:0]        modrm;
  logic              direction;     // Set means reg, r/m
  logic              bitsize;       // Clear means byte operands
  logic              osize;         // Toggled by 66
  logic              override;      // Segment prefix seen
  logic              hasModrm;
  logic [`REG_W-1:0] op1;
  logic [`REG_W-1:0] op2;
  logic              memRm;
  opClass            cls;

  // ------------------------------------------------------------
  // Byte classification
  // ------------------------------------------------------------
  function automatic opClass classify(input logic [7:0] b);
    casez (b)
      8'h26, 8'h2E, 8'h36, 8'h3E, 8'h66,
      8'hF0, 8'h64, 8'h65, 8'hF2, 8'hF3, 8'h67: return PREFIX;
      8'b00??_?0??,                  // ALU forms
      8'b1000_????,                  // 80-8F
      8'b1100_01??,                  // C4-C7
      8'b1101_00??,                  // Shifts D0-D3
      8'b1101_1???,                  // FPU escapes
      8'b1111_?11?,                  // F6-F7, FE-FF
      8'h62, 8'h63, 8'h69, 8'h6B,
      8'hC0, 8'hC1:                  return WITH_MODRM;
      default:                       return PLAIN;
    endcase
  endfunction

  // Mod 01, mod 10 or direct address
  function automatic logic needDisp(input logic [7:0] m);
    return (m[7:6] == 2'b01) || (m[7:6] == 2'b10)
        || (m[7:6] == 2'b00 && m[2:0] == 3'b110);
  endfunction

  // Memory forms that default to SS
  function automatic logic bpForm(input logic [7:0] m);
    return (m[7:6] != 2'b11)
        && ((m[2:1] == 2'b01) || (m[2:0] == 3'b110 && m[7:6] != 2'b00));
  endfunction

  assign cls     = classify(din);
  assign memRm   = (modrm[7:6] != 2'b11);
  assign sizeSel = {osize & bitsize, bitsize};   // Also the operand sizeM1

  // Reg field first, r/m register once the first read is done
  always_comb begin
    if (state == MODRM && phase == MR_DECODE) regSel = din[5:3];
    else if (phase == MR_REGREAD && immBusy)  regSel = modrm[5:3];
    else                                      regSel = modrm[2:0];
  end

  // ------------------------------------------------------------
  // Commands to address unit and loader
  // ------------------------------------------------------------
  always_comb begin
    cmd     = '0;
    cmd.seg = SEG_DS;
    imm     = '0;
    case (state)
      INIT: cmd.setSeg = 1'b1;       // DS default
      FETCH: begin
        cmd.ipStep = 1'b1;
        case (din)
          8'h26: begin cmd.setSeg = 1'b1; cmd.seg = SEG_ES; end
          8'h2E: begin cmd.setSeg = 1'b1; cmd.seg = SEG_CS; end
          8'h36: begin cmd.setSeg = 1'b1; cmd.seg = SEG_SS; end
          8'h3E: begin cmd.setSeg = 1'b1; cmd.seg = SEG_DS; end
          default: ;
        endcase
      end
      MODRM: begin
        if (immBusy) begin
          cmd.memMode = (phase == MR_CAPTURE);  // Hold segment:EA for operand bytes
        end else begin
          case (phase)
            MR_DECODE: begin
              cmd.ipStep     = 1'b1;
              cmd.loadEaBase = 1'b1;
              if (!override && bpForm(din)) begin
                cmd.setSeg = 1'b1;
                cmd.seg    = SEG_SS;
              end
              imm.start  = needDisp(din);
              imm.sizeM1 = {1'b0, din[7:6] != 2'b01};  // Disp8 or disp16
            end
            MR_REGREAD: begin
              cmd.addDisp  = needDisp(modrm);
              cmd.dispWide = (modrm[7:6] != 2'b01);
              cmd.memMode  = memRm;
              imm.start    = memRm;
              imm.sizeM1   = sizeSel;
            end
            default: cmd.restoreEa = 1'b1;
          endcase
        end
      end
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clk25 or negedge arstN) begin
    if (!arstN) begin
      state      <= INIT;
      phase      <= MR_DECODE;
      osize      <= 1'b0;
      override   <= 1'b0;
      hasModrm   <= 1'b0;
      instrValid <= 1'b0;
    end else begin
      instrValid <= 1'b0;
      if (!immBusy) begin            // Frozen while loader runs
        case (state)
          INIT: begin
            osize    <= 1'b0;
            override <= 1'b0;
            hasModrm <= 1'b0;
            phase    <= MR_DECODE;
            state    <= FETCH;
          end
          FETCH: begin
            case (cls)
              PREFIX: begin
                if (din == 8'h66) osize <= ~osize;
                if (din == 8'h26 || din == 8'h2E || din == 8'h36 || din == 8'h3E) begin
                  override <= 1'b1;
                end
              end
              WITH_MODRM: begin
                hasModrm <= 1'b1;
                state    <= MODRM;
              end
              default: state <= EXEC;
            endcase
          end
          MODRM: begin
            case (phase)
              MR_DECODE:  phase <= MR_REGREAD;
              MR_REGREAD: phase <= MR_CAPTURE;
              default:    state <= EXEC;
            endcase
          end
          default: begin
            instrValid <= 1'b1;      // One-cycle report strobe
            state      <= INIT;
          end
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Opcode, ModRM and operands
  // ------------------------------------------------------------
  always_ff @(posedge clk25) begin
    if (!immBusy) begin
      case (state)
        INIT: begin
          op1 <= '0;
          op2 <= '0;
        end
        FETCH: begin
          if (cls != PREFIX) begin
            opcode    <= din;
            direction <= din[1];
            bitsize   <= din[0];
          end
        end
        MODRM: begin
          case (phase)
            MR_DECODE: modrm <= din;
            MR_REGREAD: begin        // Reg field operand
              if (direction) op1 <= regValue;
              else           op2 <= regValue;
            end
            default: begin           // r/m operand, register or memory
              if (direction) op2 <= memRm ? immValue : regValue;
              else           op1 <= memRm ? immValue : regValue;
            end
          endcase
        end
        default: begin
          info.opcode   <= opcode;
          info.segment  <= curSeg;
          info.ea       <= hasModrm ? curEa : 16'h0000;
          info.op1      <= op1;
          info.op2      <= op2;
          info.osize    <= osize;
          info.hasModrm <= hasModrm;
        end
      endcase
    end
  end

endmodule

// File: logic/immLoader.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module immLoader import cpu_pkg::*; (
  input  logic              clk25,
  input  logic              arstN,
  input  logic [7:0]        din,
  input  immReq             req,
  output logic              busy,
  output logic              step,      // One byte taken this cycle
  output logic [`REG_W-1:0] value
);

  logic [1:0] phase;                 // Current byte lane
  logic [1:0] lastPhase;

  // Control
  always_ff @(posedge clk25 or negedge arstN) begin
    if (!arstN) begin
      busy      <= 1'b0;
      phase     <= 2'd0;
      lastPhase <= 2'd0;
    end else if (req.start) begin
      busy      <= 1'b1;
      phase     <= 2'd0;
      lastPhase <= req.sizeM1;
    end else if (busy) begin
      phase <= phase + 2'd1;
      if (phase == lastPhase) begin
        busy <= 1'b0;                // Last byte stored this cycle
      end
    end
  end

  // Little-endian gather, upper lanes stay zero for short loads
  always_ff @(posedge clk25) begin
    if (req.start) begin
      value <= '0;
    end else if (busy) begin
      value[{phase, 3'b000} +: 8] <= din;
    end
  end

  assign step = busy;                // Address unit advances IP or EA

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module regFile (
  input  logic              clk25,
  input  logic              arstN,
  input  logic [7:0]        din,       // ModRM byte during decode
  input  logic [2:0]        regSel,
  input  logic [1:0]        sizeSel,   // 00 byte, 01 word, 11 dword
  output logic [`REG_W-1:0] regValue,
  output logic [`OFS_W-1:0] eaBase
);

  logic [`REG_W-1:0] gpr [8];        // EAX ECX EDX EBX ESP EBP ESI EDI
  logic [`REG_W-1:0] sized;
  logic [`OFS_W-1:0] bx, bp, si, di;

  // Fixed contents loaded on reset only
  always_ff @(posedge clk25 or negedge arstN) begin
    if (!arstN) begin
      gpr[0] <= `RST_EAX;
      gpr[1] <= `RST_ECX;
      gpr[2] <= `RST_EDX;
      gpr[3] <= `RST_EBX;
      gpr[4] <= `RST_ESP;
      gpr[5] <= `RST_EBP;
      gpr[6] <= `RST_ESI;
      gpr[7] <= `RST_EDI;
    end
  end

  // ------------------------------------------------------------
  // Sized read port
  // ------------------------------------------------------------
  always_comb begin
    case (sizeSel)
      2'b00: begin                   // AL..BL then AH..BH
        if (regSel[2]) sized = {24'h0, gpr[{1'b0, regSel[1:0]}][15:8]};
        else           sized = {24'h0, gpr[regSel][7:0]};
      end
      2'b01:   sized = {16'h0, gpr[regSel][15:0]};
      default: sized = gpr[regSel];
    endcase
  end

  always_ff @(posedge clk25) begin
    regValue <= sized;               // Valid one cycle after regSel
  end

  // ------------------------------------------------------------
  // 16-bit ModRM base straight from din
  // ------------------------------------------------------------
  assign bx = gpr[3][15:0];
  assign bp = gpr[5][15:0];
  assign si = gpr[6][15:0];
  assign di = gpr[7][15:0];

  always_comb begin
    case (din[2:0])
      3'b000: eaBase = bx + si;
      3'b001: eaBase = bx + di;
      3'b010: eaBase = bp + si;
      3'b011: eaBase = bp + di;
      3'b100: eaBase = si;
      3'b101: eaBase = di;
      3'b110: eaBase = (din[7:6] == 2'b00) ? 16'h0000 : bp;  // Direct form has no base
      default: eaBase = bx;
    endcase
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module cpuTb -o cpuSim

# Simulation exit status is checked through the log
./obj_dir/cpuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: verification/cpuTbModel.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// ------------------------------------------------------------
// Memory model, code below 10000, pattern above
// ------------------------------------------------------------
logic [7:0] codeMem [0:65535];

function automatic logic [7:0] memByte(input logic [19:0] a);
  if (a[19:16] == 4'h0) begin
    return codeMem[a[15:0]];
  end
  return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]} ^ 8'h5A;  // Whole address folded in
endfunction

// Little-endian read, offset wraps inside the segment
function automatic logic [31:0] memRead(input logic [15:0] seg, input logic [15:0] ofs,
                                        input int n);
  logic [31:0] v;
  logic [15:0] a;
  v = '0;
  for (int i = 0; i < n; i++) begin
    a = ofs + i[15:0];
    v[8*i +: 8] = memByte({seg, 4'h0} + {4'h0, a});
  end
  return v;
endfunction

function automatic logic [31:0] regInit(input logic [2:0] idx);
  case (idx)
    3'd0:    return `RST_EAX;
    3'd1:    return `RST_ECX;
    3'd2:    return `RST_EDX;
    3'd3:    return `RST_EBX;
    3'd4:    return `RST_ESP;
    3'd5:    return `RST_EBP;
    3'd6:    return `RST_ESI;
    default: return `RST_EDI;
  endcase
endfunction

// Byte regs AL CL DL BL AH CH DH BH
function automatic logic [31:0] regRead(input logic [2:0] idx, input int n);
  logic [31:0] v;
  v = regInit(n == 1 ? {1'b0, idx[1:0]} : idx);
  if (n == 1) return idx[2] ? {24'h0, v[15:8]} : {24'h0, v[7:0]};
  if (n == 2) return {16'h0, v[15:0]};
  return v;
endfunction

function automatic logic isPrefix(input logic [7:0] b);
  return b == 8'h26 || b == 8'h2E || b == 8'h36 || b == 8'h3E || b == 8'h66
      || b == 8'hF0 || b == 8'h64 || b == 8'h65 || b == 8'hF2 || b == 8'hF3
      || b == 8'h67;
endfunction

// Opcodes followed by a ModRM byte
function automatic logic needsModrm(input logic [7:0] b);
  if (b < 8'h40) return !b[2];                     // ALU block
  if (b >= 8'h80 && b <= 8'h8F) return 1'b1;
  if (b >= 8'hC4 && b <= 8'hC7) return 1'b1;
  if (b >= 8'hD0 && b <= 8'hD3) return 1'b1;       // Shift group
  if (b >= 8'hD8 && b <= 8'hDF) return 1'b1;       // FPU escape
  return b == 8'hF6 || b == 8'hF7 || b == 8'hFE || b == 8'hFF
      || b == 8'h62 || b == 8'h63 || b == 8'h69 || b == 8'h6B
      || b == 8'hC0 || b == 8'hC1;
endfunction

`endif

// File: verification/cpuTb.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpuTb import cpu_pkg::*; ();

  logic               clk25;
  logic               arstN;
  logic [7:0]         din;
  logic [`ADDR_W-1:0] address;
  logic               instrValid;
  instrInfo           info;

  logic [7:0]  prog[$];             // Program image built before reset
  instrInfo    expQ[$];
  instrInfo    want;
  logic [`ADDR_W-1:0] addrQ[$];     // Fetch address of the following instruction
  logic [`ADDR_W-1:0] wantAddr;
  int          seed;
  int          checked;
  int          total;

  `include "cpuTbModel.svh"

  cpuTop dut0 (
    .clk25      (clk25),
    .arstN      (arstN),
    .din        (din),
    .address    (address),
    .instrValid (instrValid),
    .info       (info)
  );

  initial begin
    clk25 = 1'b0;
    forever #20 clk25 = ~clk25;
  end

  always_comb din = memByte(address);  // Combinational memory

  // ------------------------------------------------------------
  // Reference decode of one instruction at pc
  // ------------------------------------------------------------
  function automatic void decodeAt(inout int unsigned pc, output instrInfo r);
    logic [7:0]  b;
    logic [7:0]  m;
    logic [7:0]  lo;
    logic        osz;
    logic        ovr;
    logic        viaBp;
    logic [15:0] seg;
    logic [15:0] ea;
    logic [15:0] base;
    logic [31:0] regOp;
    logic [31:0] rmOp;
    int          n;
    osz = 1'b0;
    ovr = 1'b0;
    seg = `RST_DS;
    b = codeMem[pc[15:0]];
    pc = pc + 1;
    while (isPrefix(b)) begin
      if (b == 8'h66) osz = ~osz;
      if (b == 8'h26) seg = `RST_ES;
      if (b == 8'h2E) seg = `RST_CS;
      if (b == 8'h36) seg = `RST_SS;
      if (b == 8'h3E) seg = `RST_DS;
      if (b == 8'h26 || b == 8'h2E || b == 8'h36 || b == 8'h3E) ovr = 1'b1;
      b = codeMem[pc[15:0]];
      pc = pc + 1;
    end
    r = '0;
    r.opcode = b;
    r.osize  = osz;
    if (needsModrm(b)) begin
      m = codeMem[pc[15:0]];
      pc = pc + 1;
      viaBp = 1'b0;
      case (m[2:0])                 // Base sum from r/m bits
        3'd0: base = 16'(`RST_EBX + `RST_ESI);
        3'd1: base = 16'(`RST_EBX + `RST_EDI);
        3'd2: begin
          base  = 16'(`RST_EBP + `RST_ESI);
          viaBp = 1'b1;
        end
        3'd3: begin
          base  = 16'(`RST_EBP + `RST_EDI);
          viaBp = 1'b1;
        end
        3'd4: base = 16'(`RST_ESI);
        3'd5: base = 16'(`RST_EDI);
        3'd6: begin
          viaBp = (m[7:6] != 2'b00);   // Mod 00 is the direct address
          base  = viaBp ? 16'(`RST_EBP) : 16'h0000;
        end
        default: base = 16'(`RST_EBX);
      endcase
      ea = base;
      if (m[7:6] == 2'b01) begin
        lo = codeMem[pc[15:0]];
        pc = pc + 1;
        ea = ea + {{8{lo[7]}}, lo};
      end else if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && m[2:0] == 3'd6)) begin
        lo = codeMem[pc[15:0]];
        ea = ea + {codeMem[pc[15:0] + 16'd1], lo};
        pc = pc + 2;
      end
      // BP forms default to SS
      if (!ovr && viaBp && m[7:6] != 2'b11)
        seg = `RST_SS;
      n = !b[0] ? 1 : (osz ? 4 : 2);
      regOp = regRead(m[5:3], n);
      rmOp  = (m[7:6] == 2'b11) ? regRead(m[2:0], n) : memRead(seg, ea, n);
      r.op1      = b[1] ? regOp : rmOp;
      r.op2      = b[1] ? rmOp : regOp;
      r.ea       = ea;
      r.hasModrm = 1'b1;
    end
    r.segment = seg;
  endfunction

  // ------------------------------------------------------------
  // Program building
  // ------------------------------------------------------------
  task automatic emitBytes(input logic [31:0] seq, input int count);
    for (int i = count - 1; i >= 0; i--) prog.push_back(seq[8*i +: 8]);
  endtask

  task automatic emitRandom();
    logic [31:0] r;
    logic [31:0] r2;
    logic [7:0]  pfx [11];
    logic [7:0]  m;
    int          k;
    pfx = '{8'h26, 8'h2E, 8'h36, 8'h3E, 8'h66, 8'hF0, 8'h64, 8'h65, 8'hF2, 8'hF3, 8'h67};
    r  = $random(seed);
    r2 = $random(seed);
    k  = int'(r[7:4]);
    if (k > 10) k = k - 5;
    if (r[1:0] != 2'b00) prog.push_back(pfx[k]);
    if (r[8]) begin                 // Plain opcode
      prog.push_back(r[9] ? {5'b10010, r[12:10]} : {4'h4, r[13:10]});
    end else begin
      prog.push_back(r[9] ? 8'h84 + {5'h0, r[12:10]} : {2'b00, r[12:10], 1'b0, r[14:13]});
      m = r[23:16];
      prog.push_back(m);
      if (m[7:6] == 2'b01) prog.push_back(r[31:24]);
      if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && m[2:0] == 3'd6)) begin
        prog.push_back(r[31:24]);
        prog.push_back(r2[7:0]);
      end
    end
  endtask

  task automatic checkField(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "decode check stopped the run");
    end
  endtask

  // Compare process at mid-cycle
  always @(negedge clk25) begin
    if (arstN && instrValid) begin
      assert (expQ.size() != 0) else begin
        $display("Report at %0t with no instruction left to expect", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "unexpected report");
      end
      want     = expQ.pop_front();
      wantAddr = addrQ.pop_front();
      checkField("opcode", {24'h0, info.opcode}, {24'h0, want.opcode});
      checkField("segment", {16'h0, info.segment}, {16'h0, want.segment});
      checkField("ea", {16'h0, info.ea}, {16'h0, want.ea});
      checkField("op1", info.op1, want.op1);
      checkField("op2", info.op2, want.op2);
      checkField("osize", {31'h0, info.osize}, {31'h0, want.osize});
      checkField("hasModrm", {31'h0, info.hasModrm}, {31'h0, want.hasModrm});
      checkField("address", {12'h0, address}, {12'h0, wantAddr});  // Bus at next opcode
      checked = checked + 1;
    end
  end

  initial begin
    int unsigned pc;
    instrInfo    e;
    int          waitCycles;
    int          lastChecked;
    arstN   = 1'b0;
    seed    = 53110;
    checked = 0;
    for (int i = 0; i < 65536; i++) codeMem[i] = 8'h00;
    // ------------------------------------------------------------
    // Directed part
    // ------------------------------------------------------------
    emitBytes(32'h9090, 2);         // Plain opcodes
    emitBytes(32'h88C8, 2);         // Byte reg to reg
    emitBytes(32'h89D8, 2);
    emitBytes(32'h6689D8, 3);       // Dword through 66
    emitBytes(32'h8AC3, 2);         // Direction set
    emitBytes(32'h03C6, 2);
    emitBytes(32'h8B00, 2);         // [BX+SI]
    emitBytes(32'h8B063412, 4);     // Direct disp16
    emitBytes(32'h8B4610, 3);       // [BP+d8] on SS
    emitBytes(32'h268B4610, 4);
    emitBytes(32'h2E8B02, 3);
    emitBytes(32'h368B07, 3);
    emitBytes(32'h3E8B03, 3);
    emitBytes(32'h8B40F0, 3);       // Negative disp8
    emitBytes(32'h668B40F0, 4);
    emitBytes(32'h66, 1);
    emitBytes(32'h8B8600FF, 4);
    for (int i = 0; i < 40; i++) emitRandom();
    @(negedge clk25);
    for (int i = 0; i < prog.size(); i++) codeMem[i] = prog[i];
    pc = 0;
    while (pc < prog.size()) begin
      decodeAt(pc, e);
      expQ.push_back(e);
      addrQ.push_back({`RST_CS, 4'h0} + {4'h0, pc[15:0]});
    end
    total = expQ.size();
    @(negedge clk25);
    arstN = 1'b1;
    waitCycles  = 0;
    lastChecked = 0;
    while (checked < total) begin
      @(posedge clk25);
      waitCycles = (checked != lastChecked) ? 0 : waitCycles + 1;
      lastChecked = checked;
      if (waitCycles > 200) begin
        $display("Timeout waiting for report %0d of %0d", checked + 1, total);
        $display("SOME TESTS FAILED");
        $fatal(1, "no instrValid");
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
